// File: include/fw_version.svh
`ifndef fw_version_svh
`define fw_version_svh

`define major_rev   8'd3 // Interface changes
`define minor_rev   8'd2 // New features
`define bug_fix_rev 8'd0 // Fixes only

`endif

// File: rider_status.f
+incdir+include
verilog/rider_regmap_pkg.sv
verilog/rider_host_pkg.sv
verilog/soft_error_monitor.sv
verilog/status_reg_block.sv
verilog/host_cmd_port.sv
verilog/status_cmd_fifo.sv
verilog/status_read_engine.sv
verilog/rider_status_top.sv
testbench/tb_rider_status.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the status readout testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rider_status \
  -f rider_status.f \
  -o sim_rider_status

./obj_dir/sim_rider_status | tee sim.log

if grep -q "^No errors$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: testbench/tb_rider_status.sv
`include "fw_version.svh"

module tb_rider_status import rider_regmap_pkg::*, rider_host_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ack_timeout = 50; // Cycles allowed per handshake edge
  localparam int total_ops = 72; // Host commands over all tests rounded up
  localparam int op_cycles = 12; // Handshake plus pipeline with slack
  localparam int event_cycles = 136;
  localparam int watchdog_cycles = 20 * (total_ops * op_cycles + event_cycles); // 200 us

  typedef struct {
    logic [4:0]  index;
    logic [31:0] data;
    int          cycle; // Clock count when req went up
  } exp_t;

  logic          clk = 1'b0;
  logic          arst_n;
  logic          host_req;
  host_cmd_t     host_cmd;
  logic          host_ack;
  logic          evt_cs_mismatch;
  logic          evt_unknown_cmd;
  logic          evt_ddr3_overflow;
  rider_status_t status;
  soft_thres_t   thres;
  host_resp_t    resp;
  logic          resp_valid;

  logic [31:0] lcg_state = 32'he2a;
  logic [31:0] model_cnt [3]; // 0 checksum, 1 unknown TTC, 2 DDR3
  logic [2:0]  model_flag;    // Sticky flags in the same order
  exp_t        exp_q [$];     // Reads in flight
  int          cycle_cnt = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_err_base;
  string       test_name = "reset";

  rider_status_top dut (
    .clk, .arst_n, .host_req, .host_cmd, .host_ack,
    .evt_cs_mismatch, .evt_unknown_cmd, .evt_ddr3_overflow,
    .status, .thres, .resp, .resp_valid
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Expected register word from the map, the applied inputs and the model
  function automatic logic [31:0] expected_word(input logic [4:0] idx);
    logic [31:0] w;
    w = '0;
    case (idx)
      reg_fw_version: w[23:0] = {`major_rev, `minor_rev, `bug_fix_rev};
      reg_error: begin
        w[0]    = status.error_pll_unlock;
        w[1]    = status.error_unknown_ttc | model_flag[1]; // Hard bit or soft flag
        w[2]    = status.error_trig_rate;
        w[3]    = status.error_data_corrupt | model_flag[0];
        w[4]    = status.error_trig_num_from_tt;
        w[5]    = status.error_trig_num_from_cm;
        w[6]    = status.error_trig_type_from_tt;
        w[7]    = status.error_trig_type_from_cm;
        w[12:8] = status.chan_error_rc;
      end
      reg_ext_clk:   w[1:0] = {status.daq_clk_sel, status.daq_clk_en};
      reg_clk_synth: w[3:0] = {status.adcclk_clkin1_stat, status.adcclk_clkin0_stat,
                               status.adcclk_stat_ld, status.adcclk_stat};
      reg_daq_link:  w[2:0] = {model_flag[2], status.daq_almost_full, status.daq_ready};
      reg_ttc_tts:   w[10:0] = {status.tts_state, status.ttc_chan_b_info, status.ttc_ready};
      reg_fsm_state0: w[30:0] = status.cm_state;
      reg_fsm_state1: w[14:0] = {status.tp_state, status.cac_state, status.ttr_state};
      reg_acq: w[12:0] = {status.endianness_sel, status.acq_readout_pause,
                          status.fill_type, status.chan_en};
      reg_trig_info: w[13:0] = {status.trig_settings, status.acq_fifo_full,
                                status.trig_fifo_full, status.trig_delay};
      reg_trig_num:    w[23:0] = status.trig_num;
      reg_trig_ts_lsb: w = status.trig_timestamp[31:0];
      reg_trig_ts_msb: w[11:0] = status.trig_timestamp[43:32];
      reg_thres_data_corrupt: w = thres.data_corrupt;
      reg_cs_mismatch_count:  w = model_cnt[0];
      reg_thres_unknown_ttc:  w = thres.unknown_ttc;
      reg_unknown_cmd_count:  w = model_cnt[1];
      reg_thres_ddr3_ovf:     w = thres.ddr3_overflow;
      reg_ddr3_ovf_count:     w = model_cnt[2];
      default: w = '0; // Outside the map
    endcase
    return w;
  endfunction

  // Flag sets at count >= nonzero threshold and then stays set
  function automatic void update_flags();
    logic [31:0] thr [3];
    thr[0] = thres.data_corrupt;
    thr[1] = thres.unknown_ttc;
    thr[2] = thres.ddr3_overflow;
    for (int i = 0; i < 3; i++) begin
      if (thr[i] != '0 && model_cnt[i] >= thr[i]) model_flag[i] = 1'b1;
    end
  endfunction

  task automatic randomize_status();
    logic [$bits(rider_status_t)-1:0] v;
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < $bits(v); i++) begin
      if (i % 32 == 0) r = next_rand();
      v[i] = r[i % 32];
    end
    @(posedge clk);
    status <= rider_status_t'(v);
  endtask

  task automatic set_thres(input logic [31:0] dc, input logic [31:0] uttc,
                           input logic [31:0] ovf);
    soft_thres_t t;
    t.data_corrupt  = dc;
    t.unknown_ttc   = uttc;
    t.ddr3_overflow = ovf;
    @(posedge clk);
    thres <= t;
    @(posedge clk); // Monitor compares from here on
    update_flags();
  endtask

  // One cycle of event pulses with the select bits in counter order
  task automatic pulse_event(input logic [2:0] sel);
    @(posedge clk);
    evt_cs_mismatch   <= sel[0];
    evt_unknown_cmd   <= sel[1];
    evt_ddr3_overflow <= sel[2];
    for (int i = 0; i < 3; i++) begin
      if (sel[i] && model_cnt[i] != '1) model_cnt[i] = model_cnt[i] + 32'd1;
    end
  endtask

  task automatic quiet_events();
    @(posedge clk);
    evt_cs_mismatch   <= 1'b0;
    evt_unknown_cmd   <= 1'b0;
    evt_ddr3_overflow <= 1'b0;
    @(posedge clk); // Last pulse counted
    update_flags();
  endtask

  // Four-phase req/ack transfer of one command
  task automatic host_transfer(input host_op_e op, input logic [4:0] idx);
    host_cmd_t cmd;
    exp_t      e;
    int        waited;
    @(posedge clk);
    cmd.op    = op;
    cmd.index = idx;
    if (op == op_read) begin
      e.index = idx;
      e.data  = expected_word(idx);
      e.cycle = cycle_cnt;
      exp_q.push_back(e);
    end
    host_cmd <= cmd;
    host_req <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!host_ack && waited < ack_timeout);
    if (!host_ack) begin
      $display("Command for register %0d in %s got no ack", idx, test_name);
      errors++;
      if (op == op_read) void'(exp_q.pop_back()); // No response will come
    end
    host_req <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (host_ack && waited < ack_timeout);
    if (host_ack) begin
      $display("Ack stayed high after req dropped in %s", test_name);
      errors++;
    end
  endtask

  task automatic read_reg(input logic [4:0] idx);
    host_transfer(op_read, idx);
  endtask

  task automatic start_test(input string name);
    test_name     = name;
    test_err_base = errors;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) @(posedge clk);
    repeat (3) @(posedge clk); // Catch stray responses
    tests++;
    if (errors == test_err_base) $display("%s: ok", test_name);
    else $display("%s: failed with %0d errors", test_name, errors - test_err_base);
  endtask

  // Response checker samples on the falling edge
  always @(negedge clk) begin : compare
    exp_t e;
    if (arst_n && resp_valid) begin
      if (exp_q.size() == 0) begin
        $display("Response for register %0d arrived with no read pending", resp.index);
        errors++;
      end else begin
        e = exp_q.pop_front();
        checks++;
        if (resp.index !== e.index) begin
          $display("[FAIL] %s index: expected %0d, actual %0d", test_name, e.index, resp.index);
          errors++;
        end
        if (resp.data !== e.data) begin
          $display("[FAIL] %s reg %0d: expected %h, actual %h",
                   test_name, e.index, e.data, resp.data);
          errors++;
        end
        if (cycle_cnt - e.cycle < 4) begin
          $display("Response for register %0d came after only %0d cycles",
                   e.index, cycle_cnt - e.cycle);
          errors++;
        end
      end
    end
  end

  initial begin : watchdog
    #(watchdog_cycles * 10);
    $display("Watchdog expired after %0d cycles, run stopped in %s", watchdog_cycles, test_name);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    logic [31:0]   r;
    rider_status_t st;
    arst_n            = 1'b0;
    host_req          = 1'b0;
    host_cmd          = '0;
    evt_cs_mismatch   = 1'b0;
    evt_unknown_cmd   = 1'b0;
    evt_ddr3_overflow = 1'b0;
    status            = '0;
    thres             = '0;
    model_cnt         = '{default: '0};
    model_flag        = '0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;

    // Full map with thresholds too high for any flag
    start_test("register map");
    randomize_status();
    set_thres(next_rand() | 32'h0001_0000, next_rand() | 32'h0001_0000,
              next_rand() | 32'h0001_0000);
    for (int i = 0; i < num_status_regs; i++) read_reg(5'(i));
    end_test();

    start_test("out of map");
    for (int i = num_status_regs; i < 32; i++) read_reg(5'(i));
    end_test();

    start_test("counting");
    for (int i = 0; i < 60; i++) begin
      r = next_rand();
      pulse_event(r[2:0] & r[6:4]); // About one in four per counter
    end
    quiet_events();
    read_reg(reg_cs_mismatch_count);
    read_reg(reg_unknown_cmd_count);
    read_reg(reg_ddr3_ovf_count);
    read_reg(reg_error);
    read_reg(reg_daq_link);
    end_test();

    // Hard error bits low so only the soft flags show
    start_test("thresholds");
    @(posedge clk);
    st = status;
    st.error_data_corrupt = 1'b0;
    st.error_unknown_ttc  = 1'b0;
    status <= st;
    set_thres(model_cnt[0] + 32'd3, 32'd0, model_cnt[2] + 32'd2);
    read_reg(reg_error);
    read_reg(reg_daq_link);
    pulse_event(3'b011);
    pulse_event(3'b011);
    pulse_event(3'b100);
    quiet_events(); // One short of each threshold
    read_reg(reg_error);
    read_reg(reg_daq_link);
    pulse_event(3'b111);
    pulse_event(3'b100);
    quiet_events();
    read_reg(reg_error);
    read_reg(reg_daq_link);
    read_reg(reg_cs_mismatch_count);
    read_reg(reg_unknown_cmd_count);
    read_reg(reg_ddr3_ovf_count);
    // Old flags hold and the unknown TTC flag sets at its present count
    set_thres(32'hffff_0000, model_cnt[1], 32'hffff_0000);
    read_reg(reg_error);
    read_reg(reg_daq_link);
    end_test();

    start_test("clear");
    host_transfer(op_clear_counts, 5'd0);
    model_cnt  = '{default: '0};
    model_flag = '0;
    read_reg(reg_error);
    read_reg(reg_daq_link);
    read_reg(reg_cs_mismatch_count);
    read_reg(reg_unknown_cmd_count);
    read_reg(reg_ddr3_ovf_count);
    pulse_event(3'b010);
    quiet_events();
    read_reg(reg_unknown_cmd_count); // Counting resumes
    end_test();

    // Back-to-back commands with dropped nops mixed in
    start_test("burst");
    randomize_status();
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      if (r[9:8] == 2'b00) host_transfer(op_nop, 5'(r[7:0] % 19));
      else read_reg(5'(r[7:0] % 19));
    end
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verilog/host_cmd_port.sv
module host_cmd_port import rider_host_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      host_req,
  input  host_cmd_t host_cmd, // Stable while req is high
  output logic      host_ack,
  input  logic      full,
  output logic      push,
  output host_cmd_t push_cmd
);

  logic take; // New request that the FIFO can accept

  // Ack low and no push in flight, so this req is still unserved
  assign take = host_req && !host_ack && !push && !full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      push     <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      push <= take; // Single pulse per handshake
      if (push) begin
        host_ack <= 1'b1; // Command is in the FIFO now
      end else if (host_ack && !host_req) begin
        host_ack <= 1'b0; // Host released req
      end
    end
  end

  // Command captured with the push
  always_ff @(posedge clk) begin
    if (take) push_cmd <= host_cmd;
  end

  // Full is checked a cycle ahead, so the FIFO must still have room
  a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
    push |-> !full);

endmodule

// File: verilog/rider_host_pkg.sv
package rider_host_pkg;

  localparam int cmd_fifo_depth = 4;
  localparam int cmd_ptr_w = $clog2(cmd_fifo_depth);
  localparam int reg_index_w = 5; // Covers the map and the unused space above it

  typedef enum logic [1:0] {
    op_read,         // Return one status word
    op_clear_counts, // Zero the soft-error counters and flags
    op_nop
  } host_op_e;

  // One host command as it sits in the FIFO
  typedef struct packed {
    host_op_e               op;
    logic [reg_index_w-1:0] index;
  } host_cmd_t;

  // Read response back to the host
  typedef struct packed {
    logic [reg_index_w-1:0] index; // Echo of the requested register
    logic [31:0]            data;
  } host_resp_t;

endpackage

// File: verilog/rider_regmap_pkg.sv
package rider_regmap_pkg;

  localparam int num_status_regs = 19; // Words 0 to 18
  localparam int status_word_w = 32;
  localparam int num_soft_errs = 3; // Checksum, unknown TTC, DDR3 overflow

  // Raw board status, one field per source
  typedef struct packed {
    logic        error_data_corrupt;
    logic        error_trig_num_from_tt;
    logic        error_trig_type_from_tt;
    logic        error_trig_num_from_cm;
    logic        error_trig_type_from_cm;
    logic        error_pll_unlock;
    logic        error_trig_rate;
    logic        error_unknown_ttc;
    logic [4:0]  chan_error_rc;
    logic        daq_clk_sel; // External clock
    logic        daq_clk_en;
    logic        adcclk_clkin0_stat; // Synthesizer
    logic        adcclk_clkin1_stat;
    logic        adcclk_stat_ld;
    logic        adcclk_stat;
    logic        daq_almost_full; // DAQ link
    logic        daq_ready;
    logic [3:0]  tts_state;
    logic [5:0]  ttc_chan_b_info;
    logic        ttc_ready;
    logic [30:0] cm_state; // FSM states
    logic [3:0]  ttr_state;
    logic [3:0]  cac_state;
    logic [6:0]  tp_state;
    logic [4:0]  acq_readout_pause;
    logic [1:0]  fill_type;
    logic [4:0]  chan_en;
    logic        endianness_sel;
    logic        trig_fifo_full;
    logic        acq_fifo_full;
    logic [3:0]  trig_delay;
    logic [7:0]  trig_settings;
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;
  } rider_status_t;

  typedef struct packed {
    logic [status_word_w-1:0] data_corrupt;
    logic [status_word_w-1:0] unknown_ttc;
    logic [status_word_w-1:0] ddr3_overflow;
  } soft_thres_t;

  // Monitor results, counts plus sticky flags
  typedef struct packed {
    logic [status_word_w-1:0] cs_mismatch_count;
    logic [status_word_w-1:0] unknown_cmd_count;
    logic [status_word_w-1:0] ddr3_overflow_count;
    logic                     error_data_corrupt;
    logic                     error_unknown_ttc;
    logic                     ddr3_overflow_warning;
  } soft_count_t;

  typedef enum logic [4:0] {
    reg_fw_version         = 5'd0,
    reg_error              = 5'd1,
    reg_ext_clk            = 5'd2,
    reg_clk_synth          = 5'd3,
    reg_daq_link           = 5'd4,
    reg_ttc_tts            = 5'd5,
    reg_fsm_state0         = 5'd6,
    reg_fsm_state1         = 5'd7,
    reg_acq                = 5'd8,
    reg_trig_info          = 5'd9,
    reg_trig_num           = 5'd10,
    reg_trig_ts_lsb        = 5'd11,
    reg_trig_ts_msb        = 5'd12,
    reg_thres_data_corrupt = 5'd13,
    reg_cs_mismatch_count  = 5'd14,
    reg_thres_unknown_ttc  = 5'd15,
    reg_unknown_cmd_count  = 5'd16,
    reg_thres_ddr3_ovf     = 5'd17,
    reg_ddr3_ovf_count     = 5'd18
  } status_reg_e;

endpackage

// File: verilog/rider_status_top.sv
module rider_status_top import rider_host_pkg::*, rider_regmap_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          host_req,
  input  host_cmd_t     host_cmd,
  output logic          host_ack,
  input  logic          evt_cs_mismatch,
  input  logic          evt_unknown_cmd,
  input  logic          evt_ddr3_overflow,
  input  rider_status_t status,
  input  soft_thres_t   thres,
  output host_resp_t    resp,
  output logic          resp_valid
);

  soft_count_t              counts;
  logic                     clear_counts;
  logic                     push;        // Port to FIFO
  host_cmd_t                push_cmd;
  logic                     full;
  logic                     pop;         // FIFO to engine
  host_cmd_t                pop_cmd;
  logic                     empty;
  logic [4:0]               rd_index;    // Engine to register block
  logic [status_word_w-1:0] rd_word;

  soft_error_monitor u_monitor (
    .clk, .arst_n,
    .evt_cs_mismatch, .evt_unknown_cmd, .evt_ddr3_overflow,
    .thres, .clear_counts, .counts
  );

  status_reg_block u_regs (
    .status, .counts, .thres, .rd_index, .rd_word
  );

  host_cmd_port u_port (
    .clk, .arst_n, .host_req, .host_cmd, .host_ack,
    .full, .push, .push_cmd
  );

  status_cmd_fifo u_fifo (
    .clk, .arst_n, .push, .push_cmd, .pop, .pop_cmd, .full, .empty
  );

  status_read_engine u_engine (
    .clk, .arst_n, .empty, .pop_cmd, .pop, .rd_index, .rd_word,
    .clear_counts, .resp, .resp_valid
  );

endmodule

// File: verilog/soft_error_monitor.sv
module soft_error_monitor import rider_regmap_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        evt_cs_mismatch,   // One-cycle pulses
  input  logic        evt_unknown_cmd,
  input  logic        evt_ddr3_overflow,
  input  soft_thres_t thres,
  input  logic        clear_counts,
  output soft_count_t counts
);

  // Index 0 checksum, 1 unknown TTC, 2 DDR3 overflow
  logic [num_soft_errs-1:0][status_word_w-1:0] cnt;
  logic [num_soft_errs-1:0][status_word_w-1:0] cnt_nxt;
  logic [num_soft_errs-1:0][status_word_w-1:0] thr;
  logic [num_soft_errs-1:0]                    evt;
  logic [num_soft_errs-1:0]                    flag; // Sticky

  assign evt    = {evt_ddr3_overflow, evt_unknown_cmd, evt_cs_mismatch};
  assign thr[0] = thres.data_corrupt;
  assign thr[1] = thres.unknown_ttc;
  assign thr[2] = thres.ddr3_overflow;

  // Saturating increment
  always_comb begin
    for (int i = 0; i < num_soft_errs; i++) begin
      cnt_nxt[i] = (evt[i] && (cnt[i] != '1)) ? cnt[i] + 1'b1 : cnt[i];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt  <= '0;
      flag <= '0;
    end else if (clear_counts) begin // Clear wins over a same-cycle event
      cnt  <= '0;
      flag <= '0;
    end else begin
      for (int i = 0; i < num_soft_errs; i++) begin
        cnt[i] <= cnt_nxt[i];
        // Compare against the new count so flag and count agree
        if ((thr[i] != '0) && (cnt_nxt[i] >= thr[i])) flag[i] <= 1'b1;
      end
    end
  end

  assign counts.cs_mismatch_count     = cnt[0];
  assign counts.unknown_cmd_count     = cnt[1];
  assign counts.ddr3_overflow_count   = cnt[2];
  assign counts.error_data_corrupt    = flag[0];
  assign counts.error_unknown_ttc     = flag[1];
  assign counts.ddr3_overflow_warning = flag[2];

  // A zero threshold disables its flag
  for (genvar g = 0; g < num_soft_errs; g++) begin : g_flag_chk
    a_flag_needs_thres: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(flag[g]) |-> ($past(thr[g]) != '0));
  end

endmodule

// File: verilog/status_cmd_fifo.sv
module status_cmd_fifo import rider_host_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      push,
  input  host_cmd_t push_cmd,
  input  logic      pop,
  output host_cmd_t pop_cmd, // Head, no read delay
  output logic      full,
  output logic      empty
);

  host_cmd_t            mem [cmd_fifo_depth];
  logic [cmd_ptr_w-1:0] wr_ptr;
  logic [cmd_ptr_w-1:0] rd_ptr;
  logic [cmd_ptr_w:0]   count; // Occupancy, one extra bit for full
  logic                 wr_en;
  logic                 rd_en;

  assign full  = (count == (cmd_ptr_w + 1)'(cmd_fifo_depth));
  assign empty = (count == '0);
  assign wr_en = push && !full;
  assign rd_en = pop && !empty;

  assign pop_cmd = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) wr_ptr <= (wr_ptr == cmd_ptr_w'(cmd_fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= (rd_ptr == cmd_ptr_w'(cmd_fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_ptr] <= push_cmd;
  end

  // Engine must only pop a valid head
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    pop |-> !empty);

endmodule

// File: verilog/status_read_engine.sv
module status_read_engine import rider_host_pkg::*, rider_regmap_pkg::*; (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     empty,
  input  host_cmd_t                pop_cmd,
  output logic                     pop,
  output logic [4:0]               rd_index,
  input  logic [status_word_w-1:0] rd_word, // Combinational from the register block
  output logic                     clear_counts,
  output host_resp_t               resp,
  output logic                     resp_valid
);

  // Hold off one cycle behind a clear so a following read sees zeroed counts
  assign pop      = !empty && !clear_counts;
  assign rd_index = pop_cmd.index;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      resp_valid   <= 1'b0;
      clear_counts <= 1'b0;
    end else begin
      resp_valid   <= pop && (pop_cmd.op == op_read);
      clear_counts <= pop && (pop_cmd.op == op_clear_counts);
    end
  end

  // Response payload, word taken at the pop
  always_ff @(posedge clk) begin
    if (pop) begin
      case (pop_cmd.op)
        op_read: begin
          resp.index <= pop_cmd.index;
          resp.data  <= rd_word;
        end
        default: resp <= resp; // Clear and nop leave it alone
      endcase
    end
  end

endmodule

// File: verilog/status_reg_block.sv
`include "fw_version.svh"

module status_reg_block import rider_regmap_pkg::*; (
  input  rider_status_t            status,
  input  soft_count_t              counts,
  input  soft_thres_t              thres,
  input  logic [4:0]               rd_index,
  output logic [status_word_w-1:0] rd_word
);

  logic [status_word_w-1:0] words [num_status_regs];
  logic                     err_data_corrupt; // Hard bit or monitor flag
  logic                     err_unknown_ttc;

  assign err_data_corrupt = status.error_data_corrupt | counts.error_data_corrupt;
  assign err_unknown_ttc  = status.error_unknown_ttc | counts.error_unknown_ttc;

  always_comb begin
    words[reg_fw_version] = {8'd0, `major_rev, `minor_rev, `bug_fix_rev};
    // Error word, hard errors in the low byte
    words[reg_error]      = {19'd0, status.chan_error_rc,
                             status.error_trig_type_from_cm, status.error_trig_type_from_tt,
                             status.error_trig_num_from_cm, status.error_trig_num_from_tt,
                             err_data_corrupt, status.error_trig_rate,
                             err_unknown_ttc, status.error_pll_unlock};
    words[reg_ext_clk]    = {30'd0, status.daq_clk_sel, status.daq_clk_en};
    words[reg_clk_synth]  = {28'd0, status.adcclk_clkin1_stat, status.adcclk_clkin0_stat,
                             status.adcclk_stat_ld, status.adcclk_stat};
    words[reg_daq_link]   = {29'd0, counts.ddr3_overflow_warning, // Warning in bit 2
                             status.daq_almost_full, status.daq_ready};
    words[reg_ttc_tts]    = {21'd0, status.tts_state, status.ttc_chan_b_info, status.ttc_ready};
    words[reg_fsm_state0] = {1'd0, status.cm_state};
    words[reg_fsm_state1] = {17'd0, status.tp_state, status.cac_state, status.ttr_state};
    words[reg_acq]        = {19'd0, status.endianness_sel, status.acq_readout_pause,
                             status.fill_type, status.chan_en};
    words[reg_trig_info]  = {18'd0, status.trig_settings, status.acq_fifo_full,
                             status.trig_fifo_full, status.trig_delay};
    words[reg_trig_num]   = {8'd0, status.trig_num};
    words[reg_trig_ts_lsb] = status.trig_timestamp[31:0];
    words[reg_trig_ts_msb] = {20'd0, status.trig_timestamp[43:32]};
    // Soft errors, threshold then count
    words[reg_thres_data_corrupt] = thres.data_corrupt;
    words[reg_cs_mismatch_count]  = counts.cs_mismatch_count;
    words[reg_thres_unknown_ttc]  = thres.unknown_ttc;
    words[reg_unknown_cmd_count]  = counts.unknown_cmd_count;
    words[reg_thres_ddr3_ovf]     = thres.ddr3_overflow;
    words[reg_ddr3_ovf_count]     = counts.ddr3_overflow_count;
  end

  // Indices past the map read as zero
  assign rd_word = (rd_index < 5'(num_status_regs)) ? words[rd_index] : '0;

endmodule
